// ==== lsu_pipe.f ====
+incdir+design
+incdir+bench
design/mem_access_pkg.sv
design/wb_select_pkg.sv
design/lsu_agen_stage.sv
design/lsu_data_mem.sv
design/lsu_load_wb_stage.sv
design/lsu_pipe_top.sv
bench/lsu_pipe_tb.sv

// ==== Makefile ====
# Verilator flow for the LSU pipeline testbench

TOP   = lsu_pipe_tb
BUILD = obj_dir
LOG   = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f lsu_pipe.f --top-module $(TOP)

# The run passes only when the log holds the pass line
sim:
	verilator --binary --timing -j 0 -f lsu_pipe.f --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bench/lsu_pipe_tb_tasks.svh ====
// Bench model, driver and directed tests; expects the tb signals, queues and seed in scope

  // ~~~~~~~~~~~~~~~~~~~~ Memory model
  logic [7:0] model_mem [`LSU_MEM_WORDS * 8];   // Byte copy of the data memory

  function automatic logic [`LSU_XLEN-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic int access_bytes(input mem_op_e op);
    case (op)
      OP_LB, OP_LBU: return 1;
      OP_LH, OP_LHU: return 2;
      OP_LW, OP_LWU: return 4;
      default:       return 8;
    endcase
  endfunction

  function automatic int byte_base(input logic [`LSU_XLEN-1:0] addr);
    return int'((addr >> 3) % `LSU_MEM_WORDS) * 8 + int'(addr[2:0]);   // Word index wraps
  endfunction

  function automatic logic is_misaligned(input logic [`LSU_XLEN-1:0] addr, input mem_op_e op);
    return (int'(addr[2:0]) % access_bytes(op)) != 0;
  endfunction

  function automatic void model_store(input logic [`LSU_XLEN-1:0] addr,
                                      input logic [`LSU_XLEN-1:0] data, input mem_op_e op);
    if (!is_misaligned(addr, op)) begin
      for (int b = 0; b < access_bytes(op); b++) begin
        model_mem[byte_base(addr) + b] = data[8*b +: 8];
      end
    end
  endfunction

  function automatic logic [`LSU_XLEN-1:0] model_load(input logic [`LSU_XLEN-1:0] addr,
                                                      input mem_op_e op);
    logic [`LSU_XLEN-1:0] val;
    int nbytes;
    nbytes = access_bytes(op);
    val = '0;
    for (int b = 0; b < nbytes; b++) begin
      val[8*b +: 8] = model_mem[byte_base(addr) + b];
    end
    if ((op == OP_LB || op == OP_LH || op == OP_LW) && val[8*nbytes-1]) begin
      for (int i = 8 * nbytes; i < `LSU_XLEN; i++) begin
        val[i] = 1'b1;   // Sign fill
      end
    end
    return val;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~ Request driver
  task automatic drive_req(input string name, input logic [`LSU_XLEN-1:0] addr, input mem_op_e op,
                           input logic rd, input logic wr, input wb_sel_e sel,
                           input logic [`LSU_XLEN-1:0] sdata,
                           input logic [`LSU_XLEN-1:0] load_val);
    logic [`LSU_XLEN-1:0] alu;
    logic [`LSU_XLEN-1:0] csr_rd;
    alu    = rand64();
    csr_rd = rand64();
    @(negedge i_clk);
    i_req_valid  = 1'b1;
    i_addr       = addr;
    i_store_data = sdata;
    i_mem_op     = op;
    i_rd_en      = rd;
    i_wr_en      = wr;
    i_wb_sel     = sel;
    i_alu_result = alu;
    i_csr_rdata  = csr_rd;
    i_csr_result = rand64();
    exp_name_q.push_back(name);
    exp_rf_q.push_back(sel == WB_MEM ? load_val : (sel == WB_CSR ? csr_rd : alu));
    exp_csr_q.push_back(i_csr_result);
    exp_mis_q.push_back(op != OP_NONE && (rd || wr) && is_misaligned(addr, op));
  endtask

  task automatic store_op(input string name, input logic [`LSU_XLEN-1:0] addr,
                          input logic [`LSU_XLEN-1:0] data, input mem_op_e op);
    model_store(addr, data, op);
    drive_req(name, addr, op, 1'b0, 1'b1, WB_ALU, data, '0);
  endtask

  task automatic load_op(input string name, input logic [`LSU_XLEN-1:0] addr, input mem_op_e op);
    drive_req(name, addr, op, 1'b1, 1'b0, WB_MEM, rand64(), model_load(addr, op));
  endtask

  task automatic finish_requests();
    @(negedge i_clk);
    i_req_valid = 1'b0;
    i_rd_en     = 1'b0;
    i_wr_en     = 1'b0;
    while (exp_name_q.size() != 0) begin
      @(negedge i_clk);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~ Directed tests
  task automatic idle_after_reset();
    cur_test = "reset_idle";
    repeat (IDLE_CYCLES) @(negedge i_clk);   // Monitor flags any strobe here
  endtask

  task automatic dword_round_trip();
    logic [`LSU_XLEN-1:0] base;
    cur_test = "dword_round_trip";
    base = 64'h0000_0000_8000_0000;   // Wraps onto word 0
    for (int w = 0; w < 8; w++) begin
      store_op($sformatf("dword_store_%0d", w), base + (64'(w) << 3), rand64(), OP_LD);
    end
    for (int w = 0; w < 8; w++) begin
      load_op($sformatf("dword_load_%0d", w), base + (64'(w) << 3), OP_LD);
    end
    finish_requests();
  endtask

  task automatic lane_placement();
    logic [`LSU_XLEN-1:0] word_addr;
    logic [`LSU_XLEN-1:0] data;
    mem_op_e sop;
    mem_op_e uop;
    int nbytes;
    int k;
    cur_test  = "lane_placement";
    word_addr = 64'(32) << 3;
    store_op("lane_fill", word_addr, rand64(), OP_LD);
    k = 0;
    for (int w = 0; w < 3; w++) begin
      sop = (w == 0) ? OP_LB : ((w == 1) ? OP_LH : OP_LW);
      uop = (w == 0) ? OP_LBU : ((w == 1) ? OP_LHU : OP_LWU);
      nbytes = access_bytes(sop);
      for (int off = 0; off < 8; off += nbytes) begin
        data = rand64();
        data[8*nbytes-1] = k[0];   // Alternate the sign
        k++;
        store_op($sformatf("lane_st_%s_%0d", sop.name(), off), word_addr + 64'(off), data, sop);
        load_op($sformatf("lane_ld_%s_%0d", sop.name(), off), word_addr + 64'(off), sop);
        load_op($sformatf("lane_ld_%s_%0d", uop.name(), off), word_addr + 64'(off), uop);
        load_op($sformatf("lane_word_%s_%0d", sop.name(), off), word_addr, OP_LD);
      end
    end
    finish_requests();
  endtask

  task automatic misaligned_store_drop();
    logic [`LSU_XLEN-1:0] word_addr;
    mem_op_e op;
    int off;
    cur_test  = "misaligned_store";
    word_addr = 64'(40) << 3;
    store_op("mis_fill", word_addr, rand64(), OP_LD);
    for (int c = 0; c < 6; c++) begin
      op  = (c < 3) ? ((c == 1) ? OP_LHU : OP_LH) : ((c == 4) ? OP_LWU : OP_LW);
      off = (c == 0) ? 1 : ((c == 1) ? 3 : ((c == 2) ? 7 : ((c == 3) ? 2 : ((c == 4) ? 5 : 6))));
      store_op($sformatf("mis_st_%s_%0d", op.name(), off), word_addr + 64'(off), rand64(), op);
      load_op($sformatf("mis_word_%0d", c), word_addr, OP_LD);
    end
    finish_requests();
  endtask

  task automatic wb_source_select();
    cur_test = "wb_select";
    for (int i = 0; i < 8; i++) begin
      drive_req($sformatf("wb_sel_%0d", i), (64'(i) << 3) + 64'(i), OP_NONE, (i % 4) >= 2,
                (i % 4) < 2, (i % 2 == 0) ? WB_ALU : WB_CSR, rand64(), '0);
    end
    for (int i = 0; i < 8; i++) begin
      load_op($sformatf("wb_sel_word_%0d", i), 64'(i) << 3, OP_LD);   // Stores were ignored
    end
    finish_requests();
  endtask

  task automatic back_to_back_traffic();
    logic [`LSU_XLEN-1:0] addr;
    mem_op_e real_ops[7];
    mem_op_e op;
    int word;
    int off;
    cur_test = "back_to_back";
    real_ops = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWU, OP_LD};
    for (int w = 0; w < RANDOM_WORDS; w++) begin
      store_op($sformatf("b2b_fill_%0d", w), 64'(w) << 3, rand64(), OP_LD);
    end
    word = 0;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      op  = real_ops[$unsigned($random(seed)) % 7];
      off = $unsigned($random(seed)) % 8;
      off = off - off % access_bytes(op);   // Aligned only
      if (i % 4 != 1) begin
        word = $unsigned($random(seed)) % RANDOM_WORDS;   // Slot 1 reuses the store's word
      end
      addr = (rand64() << (3 + `LSU_MEM_WORDS_LOG2)) | (64'(word) << 3) | 64'(off);
      if (i % 4 == 0 || (i % 4 != 1 && $random(seed) % 2 == 0)) begin
        store_op($sformatf("b2b_st_%0d", i), addr, rand64(), op);
      end else begin
        load_op($sformatf("b2b_ld_%0d", i), addr, op);
      end
    end
    finish_requests();
  endtask

// ==== bench/lsu_pipe_tb.sv ====
// Directed LSU testbench; loads only touch words that a bench store filled, memory is not reset

`timescale 1ns/100ps

`include "lsu_settings.svh"

module lsu_pipe_tb;

  import mem_access_pkg::*;
  import wb_select_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CYCLES  = 20;
  localparam int RANDOM_WORDS = 16;
  localparam int RANDOM_OPS   = 200;
  localparam int TOTAL_REQS   = 16 + 57 + 13 + 16 + RANDOM_WORDS + RANDOM_OPS;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES + TOTAL_REQS + 100;   // Drain slack

  logic                    i_clk;
  logic                    i_rst_n;
  logic                    i_req_valid;
  logic [`LSU_XLEN-1:0]    i_addr;
  logic [`LSU_XLEN-1:0]    i_store_data;
  mem_op_e                 i_mem_op;
  logic                    i_rd_en;
  logic                    i_wr_en;
  wb_sel_e                 i_wb_sel;
  logic [`LSU_XLEN-1:0]    i_alu_result;
  logic [`LSU_XLEN-1:0]    i_csr_rdata;
  logic [`LSU_XLEN-1:0]    i_csr_result;
  logic                    o_wb_valid;
  logic [`LSU_XLEN-1:0]    o_rf_wdata;
  logic [`LSU_XLEN-1:0]    o_csr_wdata;
  logic                    o_misaligned;

  integer                  seed = 89758;
  int                      check_count = 0;
  int                      error_count = 0;
  string                   cur_test = "reset";
  logic [2:0]              req_hist;          // Requests sampled at the last three edges

  string                   exp_name_q[$];
  logic [`LSU_XLEN-1:0]    exp_rf_q[$];
  logic [`LSU_XLEN-1:0]    exp_csr_q[$];
  logic                    exp_mis_q[$];

  lsu_pipe_top dut0 (.*);

  always #(CLK_PERIOD / 2) i_clk = ~i_clk;

  // ~~~~~~~~~~~~~~~~~~~~ Compare tasks
  task automatic check_xlen(input string test, input string what,
                            input logic [`LSU_XLEN-1:0] exp, input logic [`LSU_XLEN-1:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("[ERROR] %s %s expected %h actual %h", test, what, exp, act);
    end
  endtask

  task automatic check_flag(input string test, input string what,
                            input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("[ERROR] %s %s expected %b actual %b", test, what, exp, act);
    end
  endtask

  `include "lsu_pipe_tb_tasks.svh"

  // ~~~~~~~~~~~~~~~~~~~~ Result monitor
  always @(posedge i_clk) begin
    if (!i_rst_n) begin
      req_hist <= 3'b000;
    end else begin
      req_hist <= {req_hist[1:0], i_req_valid};
    end
  end

  // Outputs settle after the rising edge, so they are read on the falling one
  always @(negedge i_clk) begin : result_monitor
    string name;
    if (i_rst_n && req_hist[2] && exp_name_q.size() == 0) begin
      error_count++;
      $display("A result was due but no request was waiting for one");
    end else if (i_rst_n && req_hist[2]) begin
      name = exp_name_q.pop_front();
      check_flag(name, "o_wb_valid", 1'b1, o_wb_valid);
      check_xlen(name, "o_rf_wdata", exp_rf_q.pop_front(), o_rf_wdata);
      check_xlen(name, "o_csr_wdata", exp_csr_q.pop_front(), o_csr_wdata);
      check_flag(name, "o_misaligned", exp_mis_q.pop_front(), o_misaligned);
    end else if (i_rst_n) begin
      check_flag(cur_test, "o_wb_valid", 1'b0, o_wb_valid);     // No strobe without a request
      check_flag(cur_test, "o_misaligned", 1'b0, o_misaligned);
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles with %0d results pending", WATCHDOG_CYCLES,
             exp_name_q.size());
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("Testbench failed");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~ Test sequence
  initial begin
    i_clk        = 1'b0;
    i_rst_n      = 1'b0;
    i_req_valid  = 1'b1;   // A misaligned load is held during reset
    i_addr       = 64'h1;
    i_store_data = '0;
    i_mem_op     = OP_LH;
    i_rd_en      = 1'b1;
    i_wr_en      = 1'b0;
    i_wb_sel     = WB_ALU;
    i_alu_result = '0;
    i_csr_rdata  = '0;
    i_csr_result = '0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    @(negedge i_clk);
    i_rst_n     = 1'b1;
    i_req_valid = 1'b0;
    i_rd_en     = 1'b0;
    idle_after_reset();
    dword_round_trip();
    lane_placement();
    misaligned_store_drop();
    wb_source_select();
    back_to_back_traffic();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== design/lsu_pipe_top.sv ====
// Load/store pipeline top, fixed 2-cycle latency, one request per cycle, no back-pressure

`timescale 1ns/100ps

`include "lsu_settings.svh"

module lsu_pipe_top (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_req_valid,
  input  logic [`LSU_XLEN-1:0]        i_addr,
  input  logic [`LSU_XLEN-1:0]        i_store_data,
  input  mem_access_pkg::mem_op_e     i_mem_op,
  input  logic                        i_rd_en,
  input  logic                        i_wr_en,
  input  wb_select_pkg::wb_sel_e      i_wb_sel,
  input  logic [`LSU_XLEN-1:0]        i_alu_result,
  input  logic [`LSU_XLEN-1:0]        i_csr_rdata,
  input  logic [`LSU_XLEN-1:0]        i_csr_result,
  output logic                        o_wb_valid,
  output logic [`LSU_XLEN-1:0]        o_rf_wdata,
  output logic [`LSU_XLEN-1:0]        o_csr_wdata,
  output logic                        o_misaligned
);

  import mem_access_pkg::*;
  import wb_select_pkg::*;

  // ~~~~~~~~~~~~~~~~~~~~ Stage 1 request
  logic                              s1_valid;
  logic [`LSU_MEM_WORDS_LOG2-1:0]    s1_word_idx;
  logic [2:0]                        s1_offset;
  lane_mask_t                        s1_mask;
  logic [`LSU_XLEN-1:0]              s1_wdata;
  logic                              s1_rd;
  logic                              s1_wr;
  logic                              s1_misaligned;
  mem_op_e                           s1_mem_op;
  wb_sel_e                           s1_wb_sel;
  logic [`LSU_XLEN-1:0]              s1_alu;
  logic [`LSU_XLEN-1:0]              s1_csr_rdata;
  logic [`LSU_XLEN-1:0]              s1_csr_result;

  logic [`LSU_XLEN-1:0]              mem_rdata;

  lsu_agen_stage u_agen (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_req_valid  (i_req_valid),
    .i_addr       (i_addr),
    .i_store_data (i_store_data),
    .i_mem_op     (i_mem_op),
    .i_rd_en      (i_rd_en),
    .i_wr_en      (i_wr_en),
    .i_wb_sel     (i_wb_sel),
    .i_alu_result (i_alu_result),
    .i_csr_rdata  (i_csr_rdata),
    .i_csr_result (i_csr_result),
    .o_valid      (s1_valid),
    .o_word_idx   (s1_word_idx),
    .o_offset     (s1_offset),
    .o_mask       (s1_mask),
    .o_wdata      (s1_wdata),
    .o_rd         (s1_rd),
    .o_wr         (s1_wr),
    .o_misaligned (s1_misaligned),
    .o_mem_op     (s1_mem_op),
    .o_wb_sel     (s1_wb_sel),
    .o_alu        (s1_alu),
    .o_csr_rdata  (s1_csr_rdata),
    .o_csr_result (s1_csr_result)
  );

  lsu_data_mem u_mem (
    .i_clk      (i_clk),
    .i_rd       (s1_rd),
    .i_wr       (s1_wr),
    .i_word_idx (s1_word_idx),
    .i_mask     (s1_mask),
    .i_wdata    (s1_wdata),
    .o_rdata    (mem_rdata)
  );

  lsu_load_wb_stage u_load_wb (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (s1_valid),
    .i_rd         (s1_rd),
    .i_offset     (s1_offset),
    .i_misaligned (s1_misaligned),
    .i_mem_op     (s1_mem_op),
    .i_wb_sel     (s1_wb_sel),
    .i_alu        (s1_alu),
    .i_csr_rdata  (s1_csr_rdata),
    .i_csr_result (s1_csr_result),
    .i_mem_rdata  (mem_rdata),
    .o_wb_valid   (o_wb_valid),
    .o_rf_wdata   (o_rf_wdata),
    .o_csr_wdata  (o_csr_wdata),
    .o_misaligned (o_misaligned)
  );

endmodule

// ==== design/lsu_load_wb_stage.sv ====
// Stages 2 and 3; load data is zero when no read was issued, misaligned loads return shifted data

`timescale 1ns/100ps

`include "lsu_settings.svh"

module lsu_load_wb_stage (
  input  logic                        i_clk,
  input  logic                        i_rst_n,
  input  logic                        i_valid,
  input  logic                        i_rd,
  input  logic [2:0]                  i_offset,
  input  logic                        i_misaligned,
  input  mem_access_pkg::mem_op_e     i_mem_op,
  input  wb_select_pkg::wb_sel_e      i_wb_sel,
  input  logic [`LSU_XLEN-1:0]        i_alu,
  input  logic [`LSU_XLEN-1:0]        i_csr_rdata,
  input  logic [`LSU_XLEN-1:0]        i_csr_result,
  input  logic [`LSU_XLEN-1:0]        i_mem_rdata,
  output logic                        o_wb_valid,
  output logic [`LSU_XLEN-1:0]        o_rf_wdata,
  output logic [`LSU_XLEN-1:0]        o_csr_wdata,
  output logic                        o_misaligned
);

  import mem_access_pkg::*;
  import wb_select_pkg::*;

  logic                   s2_valid;
  logic                   s2_rd;
  logic                   s2_misaligned;
  logic [2:0]             s2_offset;
  mem_op_e                s2_mem_op;
  wb_sel_e                s2_wb_sel;
  logic [`LSU_XLEN-1:0]   s2_alu;
  logic [`LSU_XLEN-1:0]   s2_csr_rdata;
  logic [`LSU_XLEN-1:0]   s2_csr_result;

  logic [`LSU_XLEN-1:0]   rdata;
  logic [`LSU_XLEN-1:0]   shifted;
  logic [`LSU_XLEN-1:0]   load_data;
  logic [`LSU_XLEN-1:0]   wb_data;

  // ~~~~~~~~~~~~~~~~~~~~ Stage 2 sideband
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      s2_valid      <= 1'b0;
      s2_rd         <= 1'b0;
      s2_misaligned <= 1'b0;
    end else begin
      s2_valid      <= i_valid;
      s2_rd         <= i_rd;
      s2_misaligned <= i_misaligned;
    end
  end

  always_ff @(posedge i_clk) begin
    s2_offset     <= i_offset;
    s2_mem_op     <= i_mem_op;
    s2_wb_sel     <= i_wb_sel;
    s2_alu        <= i_alu;
    s2_csr_rdata  <= i_csr_rdata;
    s2_csr_result <= i_csr_result;
  end

  // ~~~~~~~~~~~~~~~~~~~~ Load align and extend
  assign rdata   = s2_rd ? i_mem_rdata : '0;          // Memory output is stale without a read
  assign shifted = rdata >> {s2_offset, 3'b000};

  always_comb begin
    case (s2_mem_op)
      OP_LB:   load_data = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
      OP_LBU:  load_data = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
      OP_LH:   load_data = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
      OP_LHU:  load_data = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
      OP_LW:   load_data = {{(`LSU_XLEN-32){shifted[31]}}, shifted[31:0]};
      OP_LWU:  load_data = {{(`LSU_XLEN-32){1'b0}}, shifted[31:0]};
      default: load_data = shifted;                   // OP_LD, and zero for OP_NONE
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~ Writeback select
  always_comb begin
    case (s2_wb_sel)
      WB_MEM:  wb_data = load_data;
      WB_CSR:  wb_data = s2_csr_rdata;
      default: wb_data = s2_alu;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~ Stage 3 outputs
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_wb_valid   <= 1'b0;
      o_misaligned <= 1'b0;
    end else begin
      o_wb_valid   <= s2_valid;
      o_misaligned <= s2_valid & s2_misaligned;
    end
  end

  always_ff @(posedge i_clk) begin
    o_rf_wdata  <= wb_data;
    o_csr_wdata <= s2_csr_result;   // CSR value passes straight through
  end

endmodule

// ==== design/lsu_data_mem.sv ====
// Private data memory of 64-bit words with byte-lane writes; no reset, read data holds when idle

`timescale 1ns/100ps

`include "lsu_settings.svh"

module lsu_data_mem (
  input  logic                              i_clk,
  input  logic                              i_rd,
  input  logic                              i_wr,
  input  logic [`LSU_MEM_WORDS_LOG2-1:0]    i_word_idx,
  input  mem_access_pkg::lane_mask_t        i_mask,
  input  logic [`LSU_XLEN-1:0]              i_wdata,
  output logic [`LSU_XLEN-1:0]              o_rdata
);

  logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];

  // ~~~~~~~~~~~~~~~~~~~~ Write port
  always_ff @(posedge i_clk) begin
    if (i_wr) begin
      for (int b = 0; b < `LSU_XLEN / 8; b++) begin
        if (i_mask[b]) begin
          mem[i_word_idx][8*b +: 8] <= i_wdata[8*b +: 8];   // Masked lanes only
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~ Read port
  always_ff @(posedge i_clk) begin
    if (i_rd) begin
      o_rdata <= mem[i_word_idx];   // Old word if written on the same edge
    end
  end

endmodule

// ==== design/lsu_agen_stage.sv ====
// Stage 1 address decode; misaligned stores are dropped, misaligned loads are still read, no trap

`timescale 1ns/100ps

`include "lsu_settings.svh"

module lsu_agen_stage (
  input  logic                                   i_clk,
  input  logic                                   i_rst_n,
  input  logic                                   i_req_valid,
  input  logic [`LSU_XLEN-1:0]                   i_addr,
  input  logic [`LSU_XLEN-1:0]                   i_store_data,
  input  mem_access_pkg::mem_op_e                i_mem_op,
  input  logic                                   i_rd_en,
  input  logic                                   i_wr_en,
  input  wb_select_pkg::wb_sel_e                 i_wb_sel,
  input  logic [`LSU_XLEN-1:0]                   i_alu_result,
  input  logic [`LSU_XLEN-1:0]                   i_csr_rdata,
  input  logic [`LSU_XLEN-1:0]                   i_csr_result,
  output logic                                   o_valid,
  output logic [`LSU_MEM_WORDS_LOG2-1:0]         o_word_idx,
  output logic [2:0]                             o_offset,
  output mem_access_pkg::lane_mask_t             o_mask,
  output logic [`LSU_XLEN-1:0]                   o_wdata,
  output logic                                   o_rd,
  output logic                                   o_wr,
  output logic                                   o_misaligned,
  output mem_access_pkg::mem_op_e                o_mem_op,
  output wb_select_pkg::wb_sel_e                 o_wb_sel,
  output logic [`LSU_XLEN-1:0]                   o_alu,
  output logic [`LSU_XLEN-1:0]                   o_csr_rdata,
  output logic [`LSU_XLEN-1:0]                   o_csr_result
);

  import mem_access_pkg::*;

  logic [2:0]     offset;
  logic [1:0]     size;
  lane_mask_t     base_mask;
  logic [2:0]     align_bits;
  logic           real_op;
  logic           misaligned;

  // ~~~~~~~~~~~~~~~~~~~~ Decode
  assign offset  = i_addr[2:0];
  assign size    = op_size_log2(i_mem_op);
  assign real_op = (i_mem_op != OP_NONE);

  always_comb begin
    case (size)
      2'd0: begin
        base_mask  = 8'h01;
        align_bits = 3'b000;
      end
      2'd1: begin
        base_mask  = 8'h03;
        align_bits = 3'b001;
      end
      2'd2: begin
        base_mask  = 8'h0f;
        align_bits = 3'b011;
      end
      default: begin
        base_mask  = 8'hff;
        align_bits = 3'b111;
      end
    endcase
  end

  assign misaligned = i_req_valid & (i_rd_en | i_wr_en) & real_op & (|(offset & align_bits));

  // ~~~~~~~~~~~~~~~~~~~~ Stage 1 registers
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid      <= 1'b0;
      o_rd         <= 1'b0;
      o_wr         <= 1'b0;
      o_misaligned <= 1'b0;
    end else begin
      o_valid      <= i_req_valid;
      o_rd         <= i_req_valid & i_rd_en & real_op;
      o_wr         <= i_req_valid & i_wr_en & real_op & ~misaligned;   // Bad stores never write
      o_misaligned <= misaligned;
    end
  end

  always_ff @(posedge i_clk) begin
    o_word_idx   <= i_addr[3 +: `LSU_MEM_WORDS_LOG2];   // Upper address bits wrap
    o_offset     <= offset;
    o_mask       <= base_mask << offset;                 // Lanes past byte 7 fall off
    o_wdata      <= i_store_data << {offset, 3'b000};
    o_mem_op     <= i_mem_op;
    o_wb_sel     <= i_wb_sel;
    o_alu        <= i_alu_result;
    o_csr_rdata  <= i_csr_rdata;
    o_csr_result <= i_csr_result;
  end

endmodule

// ==== design/wb_select_pkg.sv ====
// Register-file writeback source select; encoding 2'b11 is unused and falls back to the ALU result

package wb_select_pkg;

  // ~~~~~~~~~~~~~~~~~~~~ Writeback source
  typedef enum logic [1:0] {
    WB_ALU = 2'b00,   // ALU result
    WB_CSR = 2'b01,   // CSR read value
    WB_MEM = 2'b10    // Aligned and extended load data
  } wb_sel_e;

endpackage

// ==== design/mem_access_pkg.sv ====
// Access opcode and lane mask types; execute-side opcode encoding, 3'b111 means no access

package mem_access_pkg;

  // ~~~~~~~~~~~~~~~~~~~~ Access opcode
  // A signed/unsigned pair of one width also encodes the store of that width
  typedef enum logic [2:0] {
    OP_LB   = 3'b000,
    OP_LBU  = 3'b001,
    OP_LH   = 3'b010,
    OP_LHU  = 3'b011,
    OP_LW   = 3'b100,
    OP_LWU  = 3'b101,
    OP_LD   = 3'b110,
    OP_NONE = 3'b111   // No memory access
  } mem_op_e;

  // ~~~~~~~~~~~~~~~~~~~~ Byte lanes
  typedef logic [7:0] lane_mask_t;   // One bit per byte of a 64-bit word

  // Log2 of the access size in bytes
  function automatic logic [1:0] op_size_log2(input mem_op_e op);
    logic [1:0] size;
    case (op)
      OP_LB, OP_LBU: size = 2'd0;
      OP_LH, OP_LHU: size = 2'd1;
      OP_LW, OP_LWU: size = 2'd2;
      OP_LD:         size = 2'd3;
      default:       size = 2'd0;   // OP_NONE never reaches memory
    endcase
    return size;
  endfunction

endpackage

// ==== design/lsu_settings.svh ====
// LSU sizing macros; LSU_XLEN must stay 64 since the byte-lane logic assumes eight lanes

`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~ Data path

`define LSU_XLEN 64                                // Address, data and result width

// ~~~~~~~~~~~~~~~~~~~~ Data memory

// Word index width, so the memory holds 2**LSU_MEM_WORDS_LOG2 words
`define LSU_MEM_WORDS_LOG2 8

`define LSU_MEM_WORDS (1 << `LSU_MEM_WORDS_LOG2)   // Addresses wrap at this word count

`endif
